// ==== Bender.yml ====
package:
  name: axis_pkt_fifo

sources:
  # Shared package
  - common/axis_fifo_pkg.sv
  # Packet FIFO RTL
  - axis_pkt_fifo/pkt_admit.sv
  - axis_pkt_fifo/pkt_ram.sv
  - axis_pkt_fifo/pkt_desc_queue.sv
  - axis_pkt_fifo/pkt_egress.sv
  - axis_pkt_fifo/axis_pkt_fifo.sv
  # Verification
  - target: test
    files:
      - verification/axis_pkt_fifo_assert.sv
      - verification/tb_axis_pkt_fifo.sv

// ==== axis_pkt_fifo/axis_pkt_fifo.sv ====
// Store-and-forward AXI4-Stream packet FIFO top level, instantiate it between a source and a sink
module axis_pkt_fifo import axis_fifo_pkg::*; #(
  parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
  parameter int USER_WIDTH  = DEFAULT_USER_WIDTH,
  parameter int DEPTH_WORDS = DEFAULT_DEPTH_WORDS,
  parameter int MAX_PKTS    = DEFAULT_MAX_PKTS,
  localparam int KEEP_W     = DATA_WIDTH / 8,
  localparam int ADDR_W     = $clog2(DEPTH_WORDS),
  localparam int SIZE_W     = $clog2(DEPTH_WORDS * KEEP_W + 1),
  localparam int CNT_W      = $clog2(MAX_PKTS + 1)
)(
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Input stream
  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  logic [DATA_WIDTH-1:0] s_tdata_i,
  input  logic [KEEP_W-1:0]     s_tkeep_i,
  input  logic                  s_tlast_i,
  input  logic [USER_WIDTH-1:0] s_tuser_i,
  // Output stream
  output logic                  m_tvalid_o,
  input  logic                  m_tready_i,
  output logic [DATA_WIDTH-1:0] m_tdata_o,
  output logic [KEEP_W-1:0]     m_tkeep_o,
  output logic                  m_tlast_o,
  output logic [USER_WIDTH-1:0] m_tuser_o,
  // Status
  output logic                  drop_o,
  output logic [ADDR_W:0]       used_words_o,
  output logic [CNT_W-1:0]      pkts_amount_o,
  output logic [SIZE_W-1:0]     pkt_size_o,
  output logic                  empty_o
);

  localparam int WORD_W = DATA_WIDTH + KEEP_W + 1 + USER_WIDTH;

  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic              commit;
  logic [ADDR_W:0]   commit_ptr;
  logic [SIZE_W-1:0] pkt_bytes;
  logic              desc_full;
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W:0]   rd_ptr;
  logic [WORD_W-1:0] rd_word;
  logic              pop;

  pkt_admit #(
    .DATA_WIDTH   (DATA_WIDTH),
    .DEPTH_WORDS  (DEPTH_WORDS)
  ) u_pkt_admit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_tvalid_i   (s_tvalid_i),
    .s_tlast_i    (s_tlast_i),
    .s_tkeep_i    (s_tkeep_i),
    .rd_ptr_i     (rd_ptr),
    .desc_full_i  (desc_full),
    .s_tready_o   (s_tready_o),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .commit_o     (commit),
    .commit_ptr_o (commit_ptr),
    .pkt_bytes_o  (pkt_bytes),
    .drop_o       (drop_o),
    .used_words_o (used_words_o)
  );

  // Each stored word packs data, keep, last and user in that order
  pkt_ram #(
    .DATA_WIDTH  (DATA_WIDTH),
    .USER_WIDTH  (USER_WIDTH),
    .DEPTH_WORDS (DEPTH_WORDS)
  ) u_pkt_ram (
    .clk_i       (clk_i),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_word_i   ({s_tdata_i, s_tkeep_i, s_tlast_i, s_tuser_i}),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .rd_word_o   (rd_word)
  );

  pkt_desc_queue #(
    .DATA_WIDTH   (DATA_WIDTH),
    .DEPTH_WORDS  (DEPTH_WORDS),
    .MAX_PKTS     (MAX_PKTS)
  ) u_pkt_desc_queue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (commit),
    .push_bytes_i (pkt_bytes),
    .pop_i        (pop),
    .head_bytes_o (pkt_size_o),
    .count_o      (pkts_amount_o),
    .full_o       (desc_full)
  );

  pkt_egress #(
    .DATA_WIDTH   (DATA_WIDTH),
    .USER_WIDTH   (USER_WIDTH),
    .DEPTH_WORDS  (DEPTH_WORDS)
  ) u_pkt_egress (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .commit_ptr_i (commit_ptr),
    .rd_word_i    (rd_word),
    .m_tready_i   (m_tready_i),
    .rd_en_o      (rd_en),
    .rd_addr_o    (rd_addr),
    .rd_ptr_o     (rd_ptr),
    .m_tvalid_o   (m_tvalid_o),
    .m_tdata_o    (m_tdata_o),
    .m_tkeep_o    (m_tkeep_o),
    .m_tlast_o    (m_tlast_o),
    .m_tuser_o    (m_tuser_o),
    .pop_o        (pop),
    .empty_o      (empty_o)
  );

endmodule

// ==== axis_pkt_fifo/pkt_admit.sv ====
// Write-side admission of the packet FIFO, decides per beat whether a word is stored or dropped
module pkt_admit import axis_fifo_pkg::*; #(
  parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
  parameter int DEPTH_WORDS = DEFAULT_DEPTH_WORDS,
  localparam int KEEP_W     = DATA_WIDTH / 8,
  localparam int ADDR_W     = $clog2(DEPTH_WORDS),
  localparam int SIZE_W     = $clog2(DEPTH_WORDS * KEEP_W + 1)
)(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              s_tvalid_i,
  input  logic              s_tlast_i,
  input  logic [KEEP_W-1:0] s_tkeep_i,
  input  logic [ADDR_W:0]   rd_ptr_i,
  input  logic              desc_full_i,
  output logic              s_tready_o,
  output logic              wr_en_o,
  output logic [ADDR_W-1:0] wr_addr_o,
  output logic              commit_o,
  output logic [ADDR_W:0]   commit_ptr_o,
  output logic [SIZE_W-1:0] pkt_bytes_o,
  output logic              drop_o,
  output logic [ADDR_W:0]   used_words_o
);

  localparam int ONES_W = $clog2(KEEP_W + 1);

  admit_state_e      state_q;
  logic [ADDR_W:0]   wr_ptr_q;
  logic [ADDR_W:0]   commit_ptr_q;
  logic [SIZE_W-1:0] bytes_q;
  logic [ADDR_W:0]   occupancy;
  logic              storage_full;
  logic              drop_beat;
  logic [ONES_W-1:0] keep_ones;

  // Overflow is handled by dropping, so the source is never stalled
  assign s_tready_o = 1'b1;

  // Tentative words count as used until they are committed or rewound
  assign occupancy    = wr_ptr_q - rd_ptr_i;
  assign storage_full = (occupancy == (ADDR_W + 1)'(DEPTH_WORDS));
  assign used_words_o = occupancy;

  // A beat is discarded inside a dropped packet, when storage is full,
  // or when a last beat finds no free descriptor
  assign drop_beat = (state_q == ADMIT_DROP) || storage_full ||
                     (s_tlast_i && desc_full_i);

  assign wr_en_o   = s_tvalid_i && !drop_beat;
  assign wr_addr_o = wr_ptr_q[ADDR_W-1:0];
  assign drop_o    = s_tvalid_i && s_tlast_i && drop_beat;
  assign commit_o  = wr_en_o && s_tlast_i;

  // The commit pointer already points past the last word on the commit edge
  assign commit_ptr_o = commit_ptr_q;

  // Number of valid bytes in the last beat
  always_comb
  begin
    keep_ones = '0;
    for (int i = 0; i < KEEP_W; i++)
    begin
      keep_ones = keep_ones + ONES_W'(s_tkeep_i[i]);
    end
  end

  // Full words so far plus the valid bytes of the closing beat
  assign pkt_bytes_o = bytes_q + SIZE_W'(keep_ones);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= ADMIT_PASS;
    end
    else if (s_tvalid_i)
    begin
      if (s_tlast_i)
      begin
        state_q <= ADMIT_PASS;
      end
      else if (drop_beat)
      begin
        state_q <= ADMIT_DROP;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q     <= '0;
      commit_ptr_q <= '0;
    end
    else if (drop_o)
    begin
      // Forget every word the dropped packet managed to write
      wr_ptr_q <= commit_ptr_q;
    end
    else if (wr_en_o)
    begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
      if (s_tlast_i)
      begin
        commit_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      bytes_q <= '0;
    end
    else if (s_tvalid_i && s_tlast_i)
    begin
      bytes_q <= '0;
    end
    else if (wr_en_o)
    begin
      bytes_q <= bytes_q + SIZE_W'(KEEP_W);
    end
  end

endmodule

// ==== axis_pkt_fifo/pkt_desc_queue.sv ====
// Queue of committed packet byte sizes, its fill level is the number of packets held
module pkt_desc_queue import axis_fifo_pkg::*; #(
  parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
  parameter int DEPTH_WORDS = DEFAULT_DEPTH_WORDS,
  parameter int MAX_PKTS    = DEFAULT_MAX_PKTS,
  localparam int SIZE_W     = $clog2(DEPTH_WORDS * (DATA_WIDTH / 8) + 1),
  localparam int CNT_W      = $clog2(MAX_PKTS + 1)
)(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              push_i,
  input  logic [SIZE_W-1:0] push_bytes_i,
  input  logic              pop_i,
  output logic [SIZE_W-1:0] head_bytes_o,
  output logic [CNT_W-1:0]  count_o,
  output logic              full_o
);

  localparam int IDX_W = (MAX_PKTS > 1) ? $clog2(MAX_PKTS) : 1;

  logic [SIZE_W-1:0] sizes [MAX_PKTS];
  logic [IDX_W-1:0]  wr_idx_q;
  logic [IDX_W-1:0]  rd_idx_q;
  logic [CNT_W-1:0]  count_q;

  // Index increment with wrap, MAX_PKTS need not be a power of two
  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    if (idx == IDX_W'(MAX_PKTS - 1))
    begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      sizes[wr_idx_q] <= push_bytes_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
      begin
        wr_idx_q <= next_idx(wr_idx_q);
      end
      if (pop_i)
      begin
        rd_idx_q <= next_idx(rd_idx_q);
      end
      if (push_i && !pop_i)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop_i && !push_i)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign head_bytes_o = sizes[rd_idx_q];
  assign count_o      = count_q;
  assign full_o       = (count_q == CNT_W'(MAX_PKTS));

endmodule

// ==== axis_pkt_fifo/pkt_egress.sv ====
// Read side of the packet FIFO, fetches committed words and presents them on the output stream
module pkt_egress import axis_fifo_pkg::*; #(
  parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
  parameter int USER_WIDTH  = DEFAULT_USER_WIDTH,
  parameter int DEPTH_WORDS = DEFAULT_DEPTH_WORDS,
  localparam int KEEP_W     = DATA_WIDTH / 8,
  localparam int ADDR_W     = $clog2(DEPTH_WORDS),
  localparam int WORD_W     = DATA_WIDTH + KEEP_W + 1 + USER_WIDTH
)(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [ADDR_W:0]       commit_ptr_i,
  input  logic [WORD_W-1:0]     rd_word_i,
  input  logic                  m_tready_i,
  output logic                  rd_en_o,
  output logic [ADDR_W-1:0]     rd_addr_o,
  output logic [ADDR_W:0]       rd_ptr_o,
  output logic                  m_tvalid_o,
  output logic [DATA_WIDTH-1:0] m_tdata_o,
  output logic [KEEP_W-1:0]     m_tkeep_o,
  output logic                  m_tlast_o,
  output logic [USER_WIDTH-1:0] m_tuser_o,
  output logic                  pop_o,
  empty_o
);

  // Fetch pointer runs ahead, the retire pointer follows accepted beats
  logic [ADDR_W:0]       fetch_ptr_q;
  logic [ADDR_W:0]       retire_ptr_q;
  logic                  ram_valid_q;
  logic                  out_valid_q;
  logic                  handshake;
  logic                  load;
  logic [DATA_WIDTH-1:0] out_data_q;
  logic [KEEP_W-1:0]     out_keep_q;
  logic                  out_last_q;
  logic [USER_WIDTH-1:0] out_user_q;

  assign handshake = out_valid_q && m_tready_i;

  // Move the RAM word into the output register when the register is free
  assign load = ram_valid_q && (!out_valid_q || handshake);

  // Only committed words are fetched, one per free slot in the pipeline
  assign rd_en_o   = (fetch_ptr_q != commit_ptr_i) && (!ram_valid_q || load);
  assign rd_addr_o = fetch_ptr_q[ADDR_W-1:0];

  // Words still in flight keep their RAM slot until they leave the output
  assign rd_ptr_o = retire_ptr_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      fetch_ptr_q  <= '0;
      retire_ptr_q <= '0;
      ram_valid_q  <= 1'b0;
      out_valid_q  <= 1'b0;
    end
    else
    begin
      if (rd_en_o)
      begin
        fetch_ptr_q <= fetch_ptr_q + 1'b1;
      end
      if (handshake)
      begin
        retire_ptr_q <= retire_ptr_q + 1'b1;
      end
      if (rd_en_o)
      begin
        ram_valid_q <= 1'b1;
      end
      else if (load)
      begin
        ram_valid_q <= 1'b0;
      end
      if (load)
      begin
        out_valid_q <= 1'b1;
      end
      else if (handshake)
      begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      {out_data_q, out_keep_q, out_last_q, out_user_q} <= rd_word_i;
    end
  end

  assign m_tvalid_o = out_valid_q;
  assign m_tdata_o  = out_data_q;
  assign m_tkeep_o  = out_keep_q;
  assign m_tlast_o  = out_last_q;
  assign m_tuser_o  = out_user_q;

  // The descriptor leaves with the final beat of its packet
  assign pop_o   = handshake && out_last_q;
  assign empty_o = !out_valid_q;

endmodule

// ==== axis_pkt_fifo/pkt_ram.sv ====
// Word storage of the packet FIFO, a simple dual-port memory with a registered read port
module pkt_ram import axis_fifo_pkg::*; #(
  parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
  parameter int USER_WIDTH  = DEFAULT_USER_WIDTH,
  parameter int DEPTH_WORDS = DEFAULT_DEPTH_WORDS,
  localparam int ADDR_W     = $clog2(DEPTH_WORDS),
  localparam int WORD_W     = DATA_WIDTH + DATA_WIDTH / 8 + 1 + USER_WIDTH
)(
  input  logic              clk_i,
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [WORD_W-1:0] wr_word_i,
  input  logic              rd_en_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [WORD_W-1:0] rd_word_o
);

  // One entry holds data, keep, last and user of a beat
  logic [WORD_W-1:0] mem [DEPTH_WORDS];

  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
    begin
      mem[wr_addr_i] <= wr_word_i;
    end
  end

  // Read data holds its value until the next read request
  always_ff @(posedge clk_i)
  begin
    if (rd_en_i)
    begin
      rd_word_o <= mem[rd_addr_i];
    end
  end

endmodule

// ==== common/axis_fifo_pkg.sv ====
// Shared admission state type and default sizes for the packet FIFO, imported by its modules
package axis_fifo_pkg;

  // Write-side state of the packet being received
  typedef enum logic
  {
    ADMIT_PASS = 1'b0,
    ADMIT_DROP = 1'b1
  } admit_state_e;

  // Width of tdata in bits, tkeep carries one bit per byte of it
  localparam int DEFAULT_DATA_WIDTH = 32;

  localparam int DEFAULT_USER_WIDTH = 1;

  // Storage depth in words, a power of two so the pointers wrap cleanly
  localparam int DEFAULT_DEPTH_WORDS = 8;

  // Number of committed packets the descriptor queue can hold
  localparam int DEFAULT_MAX_PKTS = 4;

endpackage

// ==== flist.f ====
common/axis_fifo_pkg.sv
axis_pkt_fifo/pkt_admit.sv
axis_pkt_fifo/pkt_ram.sv
axis_pkt_fifo/pkt_desc_queue.sv
axis_pkt_fifo/pkt_egress.sv
axis_pkt_fifo/axis_pkt_fifo.sv
verification/axis_pkt_fifo_assert.sv
verification/tb_axis_pkt_fifo.sv

// ==== verification/axis_pkt_fifo_assert.sv ====
// Concurrent checks on the packet FIFO top level that bind attaches to every instance
module axis_pkt_fifo_assert import axis_fifo_pkg::*; #(
  parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
  parameter int USER_WIDTH  = DEFAULT_USER_WIDTH,
  parameter int DEPTH_WORDS = DEFAULT_DEPTH_WORDS,
  parameter int MAX_PKTS    = DEFAULT_MAX_PKTS,
  localparam int KEEP_W     = DATA_WIDTH / 8,
  localparam int ADDR_W     = $clog2(DEPTH_WORDS),
  localparam int CNT_W      = $clog2(MAX_PKTS + 1)
)(
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  s_tvalid_i,
  input logic                  s_tlast_i,
  input logic                  m_tvalid_i,
  input logic                  m_tready_i,
  input logic [DATA_WIDTH-1:0] m_tdata_i,
  input logic [KEEP_W-1:0]     m_tkeep_i,
  input logic                  m_tlast_i,
  input logic [USER_WIDTH-1:0] m_tuser_i,
  input logic                  drop_i,
  input logic [ADDR_W:0]       used_words_i,
  input logic [CNT_W-1:0]      pkts_amount_i,
  input admit_state_e          admit_state_i
);

  // Count of assertion failures that the testbench polls
  int fail_count = 0;

  // A word held by a stalled sink must not change
  assert property (@(posedge clk_i) disable iff (rst_i)
    m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable(m_tdata_i) && $stable(m_tkeep_i) &&
                                  $stable(m_tlast_i) && $stable(m_tuser_i))
  else
  begin
    $error("Output stream changed while stalled");
    fail_count++;
  end

  // A last beat is only thrown away while dropping, with storage full or with no free descriptor
  assert property (@(posedge clk_i) disable iff (rst_i)
    drop_i |-> s_tvalid_i && s_tlast_i &&
               (admit_state_i == ADMIT_DROP || used_words_i == DEPTH_WORDS ||
                pkts_amount_i == MAX_PKTS))
  else
  begin
    $error("drop_o pulsed without a valid last input beat that had to be dropped");
    fail_count++;
  end

  assert property (@(posedge clk_i) disable iff (rst_i) used_words_i <= DEPTH_WORDS)
  else
  begin
    $error("used_words_o exceeds the storage depth");
    fail_count++;
  end

  // Admission starts every run ready to accept a packet
  assert property (@(posedge clk_i) $fell(rst_i) |-> admit_state_i == ADMIT_PASS)
  else
  begin
    $error("Admission state is not ADMIT_PASS after reset");
    fail_count++;
  end

endmodule

bind axis_pkt_fifo axis_pkt_fifo_assert #(
  .DATA_WIDTH    (DATA_WIDTH),
  .USER_WIDTH    (USER_WIDTH),
  .DEPTH_WORDS   (DEPTH_WORDS),
  .MAX_PKTS      (MAX_PKTS)
) u_axis_pkt_fifo_assert (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .s_tvalid_i    (s_tvalid_i),
  .s_tlast_i     (s_tlast_i),
  .m_tvalid_i    (m_tvalid_o),
  .m_tready_i    (m_tready_i),
  .m_tdata_i     (m_tdata_o),
  .m_tkeep_i     (m_tkeep_o),
  .m_tlast_i     (m_tlast_o),
  .m_tuser_i     (m_tuser_o),
  .drop_i        (drop_o),
  .used_words_i  (used_words_o),
  .pkts_amount_i (pkts_amount_o),
  .admit_state_i (u_pkt_admit.state_q)
);

// ==== verification/tb_axis_pkt_fifo.sv ====
// Directed testbench for the packet FIFO that runs as simulation top with the bound assertions
module tb_axis_pkt_fifo;

  localparam int DATA_WIDTH  = 32;
  localparam int USER_WIDTH  = 1;
  localparam int DEPTH_WORDS = 8;
  localparam int MAX_PKTS    = 4;
  localparam int KEEP_W      = DATA_WIDTH / 8;
  localparam int ADDR_W      = $clog2(DEPTH_WORDS);
  localparam int SIZE_W      = $clog2(DEPTH_WORDS * KEEP_W + 1);
  localparam int CNT_W       = $clog2(MAX_PKTS + 1);
  localparam int BEAT_W      = DATA_WIDTH + KEEP_W + 1 + USER_WIDTH;
  // All tests together take a few hundred cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic                  clk_i;
  logic                  rst_i;
  logic                  s_tvalid_i;
  logic                  s_tready_o;
  logic [DATA_WIDTH-1:0] s_tdata_i;
  logic [KEEP_W-1:0]     s_tkeep_i;
  logic                  s_tlast_i;
  logic [USER_WIDTH-1:0] s_tuser_i;
  logic                  m_tvalid_o;
  logic                  m_tready_i;
  logic [DATA_WIDTH-1:0] m_tdata_o;
  logic [KEEP_W-1:0]     m_tkeep_o;
  logic                  m_tlast_o;
  logic [USER_WIDTH-1:0] m_tuser_o;
  logic                  drop_o;
  logic [ADDR_W:0]       used_words_o;
  logic [CNT_W-1:0]      pkts_amount_o;
  logic [SIZE_W-1:0]     pkt_size_o;
  logic                  empty_o;

  // Reference model with beats packed as data, keep, last and user
  logic [BEAT_W-1:0] exp_beats [$];
  int                exp_sizes [$];
  int                mdl_used;
  int                mdl_committed;
  int                mdl_pkts;
  bit                mdl_dropping;
  bit                first_beat  = 1'b1;
  bit                stall_on    = 1'b0;
  int                cycle_count = 0;

  axis_pkt_fifo #(
    .DATA_WIDTH    (DATA_WIDTH),
    .USER_WIDTH    (USER_WIDTH),
    .DEPTH_WORDS   (DEPTH_WORDS),
    .MAX_PKTS      (MAX_PKTS)
  ) u_axis_pkt_fifo (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .s_tvalid_i    (s_tvalid_i),
    .s_tready_o    (s_tready_o),
    .s_tdata_i     (s_tdata_i),
    .s_tkeep_i     (s_tkeep_i),
    .s_tlast_i     (s_tlast_i),
    .s_tuser_i     (s_tuser_i),
    .m_tvalid_o    (m_tvalid_o),
    .m_tready_i    (m_tready_i),
    .m_tdata_o     (m_tdata_o),
    .m_tkeep_o     (m_tkeep_o),
    .m_tlast_o     (m_tlast_o),
    .m_tuser_o     (m_tuser_o),
    .drop_o        (drop_o),
    .used_words_o  (used_words_o),
    .pkts_amount_o (pkts_amount_o),
    .pkt_size_o    (pkt_size_o),
    .empty_o       (empty_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("%s (time %0t)", reason, $time);
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Drives one packet back to back and predicts its fate from the admission rule
  task automatic send_packet(input int beats);
    logic [BEAT_W-1:0]     pending [$];
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_W-1:0]     keep;
    logic [USER_WIDTH-1:0] user;
    bit                    last;
    bit                    refuse;
    for (int i = 0; i < beats; i++)
    begin
      last = (i == beats - 1);
      data = $urandom;
      keep = KEEP_W'($urandom);
      user = USER_WIDTH'($urandom);
      @(posedge clk_i);
      s_tvalid_i <= 1'b1;
      s_tdata_i  <= data;
      s_tkeep_i  <= keep;
      s_tlast_i  <= last;
      s_tuser_i  <= user;
      refuse = mdl_dropping || (mdl_used == DEPTH_WORDS) || (last && mdl_pkts == MAX_PKTS);
      if (!refuse)
      begin
        pending.push_back({data, keep, last, user});
        mdl_used++;
      end
      @(negedge clk_i);
      check_value("drop_o", drop_o, last && refuse);
      if (last && refuse)
      begin
        mdl_used = mdl_committed;
      end
      else if (last)
      begin
        foreach (pending[j])
        begin
          exp_beats.push_back(pending[j]);
        end
        exp_sizes.push_back((beats - 1) * KEEP_W + $countones(keep));
        mdl_committed = mdl_used;
        mdl_pkts++;
      end
      mdl_dropping = last ? 1'b0 : (mdl_dropping || refuse);
    end
  endtask

  task automatic end_input();
    @(posedge clk_i);
    s_tvalid_i <= 1'b0;
    s_tlast_i  <= 1'b0;
  endtask

  task automatic set_ready(input bit level);
    @(posedge clk_i);
    m_tready_i <= level;
  endtask

  task automatic wait_output_valid(input int limit);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!m_tvalid_o)
    begin
      waited++;
      if (waited > limit)
      begin
        abort_run("m_tvalid_o stayed low after a packet was committed");
      end
      @(negedge clk_i);
    end
  endtask

  // Waits until every predicted beat has left and then expects an empty FIFO
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (exp_beats.size() != 0)
    begin
      waited++;
      if (waited > 300)
      begin
        abort_run("Predicted packets did not leave the FIFO in time");
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check_value("used_words_o", used_words_o, 0);
    check_value("pkts_amount_o", pkts_amount_o, 0);
    check_value("empty_o", empty_o, 1);
    mdl_used      = 0;
    mdl_committed = 0;
    mdl_pkts      = 0;
  endtask

  // Compares every output beat and the head size at first beats with the model
  always @(negedge clk_i)
  begin : output_monitor
    logic [BEAT_W-1:0] beat;
    if (!rst_i && m_tvalid_o)
    begin
      if (exp_beats.size() == 0)
      begin
        abort_run("Output shows a word that belongs to no accepted packet");
      end
      if (first_beat)
      begin
        check_value("pkt_size_o", pkt_size_o, exp_sizes[0]);
      end
      if (m_tready_i)
      begin
        beat = exp_beats.pop_front();
        check_value("m_tdata_o", m_tdata_o, beat[BEAT_W-1 -: DATA_WIDTH]);
        check_value("m_tkeep_o", m_tkeep_o, beat[USER_WIDTH+1 +: KEEP_W]);
        check_value("m_tlast_o", m_tlast_o, beat[USER_WIDTH]);
        check_value("m_tuser_o", m_tuser_o, beat[USER_WIDTH-1:0]);
        first_beat = m_tlast_o;
        if (m_tlast_o)
        begin
          void'(exp_sizes.pop_front());
        end
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count++;
    if (u_axis_pkt_fifo.u_axis_pkt_fifo_assert.fail_count != 0)
    begin
      abort_run("A bound assertion on the FIFO failed");
    end
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      abort_run($sformatf("Run exceeded %0d cycles without finishing", TIMEOUT_CYCLES));
    end
  end

  task automatic check_reset_state();
    @(negedge clk_i);
    check_value("empty_o", empty_o, 1);
    check_value("m_tvalid_o", m_tvalid_o, 0);
    check_value("pkts_amount_o", pkts_amount_o, 0);
    check_value("used_words_o", used_words_o, 0);
    check_value("s_tready_o", s_tready_o, 1);
  endtask

  // Three packets wait behind a held output and then leave in order
  task automatic run_short_packets();
    set_ready(1'b0);
    send_packet(2);
    send_packet(3);
    send_packet(2);
    end_input();
    wait_output_valid(6);
    check_value("pkts_amount_o", pkts_amount_o, mdl_pkts);
    check_value("used_words_o", used_words_o, mdl_used);
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_value("m_tvalid_o", m_tvalid_o, 1);
    check_value("pkts_amount_o", pkts_amount_o, 3);
    set_ready(1'b1);
    wait_drain();
  endtask

  task automatic drop_oversized_packet();
    send_packet(DEPTH_WORDS + 2);
    send_packet(3);
    end_input();
    wait_drain();
  endtask

  // Fills storage and the descriptor queue while the output is held
  task automatic fill_until_overflow();
    set_ready(1'b0);
    send_packet(1);
    send_packet(2);
    send_packet(3);
    send_packet(3);
    send_packet(1);
    send_packet(1);
    end_input();
    @(negedge clk_i);
    check_value("pkts_amount_o", pkts_amount_o, mdl_pkts);
    check_value("used_words_o", used_words_o, mdl_used);
    set_ready(1'b1);
    wait_drain();
  endtask

  task automatic stream_with_stalls();
    int len_a;
    int len_b;
    stall_on = 1'b1;
    fork
      begin
        for (int b = 0; b < 6; b++)
        begin
          len_a = $urandom_range(1, 4);
          len_b = $urandom_range(1, 4);
          send_packet(len_a);
          send_packet(len_b);
          end_input();
          wait_drain();
        end
        stall_on = 1'b0;
      end
      begin
        while (stall_on)
        begin
          @(posedge clk_i);
          m_tready_i <= 1'($urandom_range(0, 1));
        end
      end
    join
    set_ready(1'b1);
  endtask

  initial
  begin
    void'($urandom(68673));
    rst_i         = 1'b1;
    s_tvalid_i    = 1'b0;
    s_tdata_i     = '0;
    s_tkeep_i     = '0;
    s_tlast_i     = 1'b0;
    s_tuser_i     = '0;
    m_tready_i    = 1'b1;
    mdl_used      = 0;
    mdl_committed = 0;
    mdl_pkts      = 0;
    mdl_dropping  = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    check_reset_state();
    run_short_packets();
    drop_oversized_packet();
    fill_until_overflow();
    stream_with_stalls();
    repeat (3) @(posedge clk_i);
    if (u_axis_pkt_fifo.u_axis_pkt_fifo_assert.fail_count == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("*** TEST FAILED ***");
      $fatal(1, "Checks failed");
    end
  end

endmodule
